//--- source/img_defs.svh
`ifndef IMG_DEFS_SVH
`define IMG_DEFS_SVH

// bus widths
`define IMG_ADDR_W 32
`define IMG_WORD_W 16
`define IMG_PIX_W 8

// external memory in bytes, split into two image buffers
`define IMG_MEM_SIZE 131072
`define IMG_BUF2_BASE (`IMG_MEM_SIZE / 2)

// status reply bytes
// bit 0 of the first one is overwritten with busy
`define IMG_STATUS_0 8'd11
`define IMG_STATUS_1 8'd22
`define IMG_STATUS_2 8'd33
`define IMG_STATUS_3 8'd44

`endif

//--- source/img_pkg.sv
`include "img_defs.svh"

package img_pkg;

   typedef logic [`IMG_PIX_W-1:0] pixel_t;
   typedef logic [`IMG_WORD_W-1:0] word_t; // lower address in low byte
   typedef logic [`IMG_ADDR_W-1:0] addr_t; // byte address
   typedef logic [15:0] dim_t; // width, height or pixel count

   // host command codes
   typedef enum logic [7:0] {
      CMD_PARAM           = 8'd0,
      CMD_SEND_IMG        = 8'd1,
      CMD_READ_IMG        = 8'd2,
      CMD_GET_STATUS      = 8'd3,
      CMD_APPLY_ADD       = 8'd4,
      CMD_APPLY_THRESHOLD = 8'd5,
      CMD_SWITCH_BUFFERS  = 8'd6,
      CMD_APPLY_INVERT    = 8'd8
   } cmd_e;

   typedef enum logic [1:0] {
      OP_ADD,
      OP_THRESHOLD,
      OP_INVERT
   } unary_op_e;

endpackage

//--- source/command_decoder.sv
`timescale 1ns/100ps
`include "img_defs.svh"

module command_decoder (
   input  logic                 clk,
   input  logic                 reset,
   input  img_pkg::cmd_e        comm_cmd,
   input  img_pkg::pixel_t      comm_data_in,
   input  logic                 comm_data_in_valid,
   output img_pkg::addr_t       mem_addr,
   output logic                 mem_wr_en,
   output img_pkg::word_t       mem_wdata,
   output logic                 op_start,
   output img_pkg::unary_op_e   op_sel,
   output img_pkg::word_t       add_value,
   output logic                 clamp,
   output img_pkg::pixel_t      threshold_level,
   output img_pkg::pixel_t      threshold_replacement,
   output logic                 threshold_upper,
   output img_pkg::dim_t        pixel_count,
   output img_pkg::addr_t       storage_base,
   output img_pkg::addr_t       input_base,
   output logic                 read_start,
   output logic                 status_start
);

   typedef enum logic [2:0] {
      ST_WAIT_CMD,
      ST_DIM,
      ST_ADD_PARAM,
      ST_THR_PARAM,
      ST_SEND_IMG
   } state_e;

   state_e         state;
   logic [1:0]     byte_cnt;
   img_pkg::dim_t  img_width;
   img_pkg::dim_t  img_height;
   img_pkg::dim_t  dim_product;
   img_pkg::dim_t  send_left;
   img_pkg::addr_t send_addr;

   assign dim_product = img_width * img_height;

   always_ff @(posedge clk) begin
      op_start     <= 1'b0;
      read_start   <= 1'b0;
      status_start <= 1'b0;
      mem_wr_en    <= 1'b0;
      if (reset) begin
         state        <= ST_WAIT_CMD;
         byte_cnt     <= '0;
         img_width    <= '0;
         img_height   <= '0;
         pixel_count  <= '0;
         send_left    <= '0;
         input_base   <= '0;
         storage_base <= `IMG_BUF2_BASE;
      end else if (comm_data_in_valid) begin
         byte_cnt <= byte_cnt + 2'd1;
         case (state)
            ST_WAIT_CMD: begin
               byte_cnt    <= '0;
               pixel_count <= dim_product; // latched once per command
               case (comm_cmd)
                  img_pkg::CMD_PARAM:           state <= ST_DIM;
                  img_pkg::CMD_SEND_IMG: begin
                     send_addr <= input_base;
                     send_left <= dim_product;
                     if (dim_product != '0) state <= ST_SEND_IMG;
                  end
                  img_pkg::CMD_READ_IMG:        read_start   <= 1'b1;
                  img_pkg::CMD_GET_STATUS:      status_start <= 1'b1;
                  img_pkg::CMD_APPLY_ADD:       state <= ST_ADD_PARAM;
                  img_pkg::CMD_APPLY_THRESHOLD: state <= ST_THR_PARAM;
                  img_pkg::CMD_SWITCH_BUFFERS: begin
                     input_base   <= storage_base;
                     storage_base <= input_base;
                  end
                  img_pkg::CMD_APPLY_INVERT: begin
                     op_sel   <= img_pkg::OP_INVERT;
                     op_start <= 1'b1; // no parameter bytes
                  end
                  default: ; // unknown codes dropped
               endcase
            end
            ST_DIM: begin // width lo, hi, height lo, hi
               case (byte_cnt)
                  2'd0: img_width[7:0]   <= comm_data_in;
                  2'd1: img_width[15:8]  <= comm_data_in;
                  2'd2: img_height[7:0]  <= comm_data_in;
                  default: begin
                     img_height[15:8] <= comm_data_in;
                     state            <= ST_WAIT_CMD;
                  end
               endcase
            end
            ST_ADD_PARAM: begin
               if (byte_cnt == 2'd0) begin
                  add_value[7:0] <= comm_data_in;
               end else if (byte_cnt == 2'd1) begin
                  add_value[15:8] <= comm_data_in;
               end else begin
                  clamp    <= comm_data_in[0];
                  op_sel   <= img_pkg::OP_ADD;
                  op_start <= 1'b1;
                  state    <= ST_WAIT_CMD;
               end
            end
            ST_THR_PARAM: begin
               if (byte_cnt == 2'd0) begin
                  threshold_level <= comm_data_in;
               end else if (byte_cnt == 2'd1) begin
                  threshold_replacement <= comm_data_in;
               end else begin
                  threshold_upper <= comm_data_in[0];
                  op_sel          <= img_pkg::OP_THRESHOLD;
                  op_start        <= 1'b1;
                  state           <= ST_WAIT_CMD;
               end
            end
            default: begin // ST_SEND_IMG packs byte pairs
               if (!send_addr[0]) begin
                  mem_wdata[7:0] <= comm_data_in;
               end else begin
                  mem_wdata[15:8] <= comm_data_in;
                  mem_wr_en       <= 1'b1;
                  mem_addr        <= {send_addr[`IMG_ADDR_W-1:1], 1'b0};
               end
               send_addr <= send_addr + 32'd1;
               send_left <= send_left - 16'd1;
               if (send_left == 16'd1) state <= ST_WAIT_CMD;
            end
         endcase
      end
   end

endmodule

//--- source/pixel_engine.sv
`timescale 1ns/100ps
`include "img_defs.svh"

module pixel_engine (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 op_start,
   input  img_pkg::unary_op_e   op_sel,
   input  img_pkg::word_t       add_value,
   input  logic                 clamp,
   input  img_pkg::pixel_t      threshold_level,
   input  img_pkg::pixel_t      threshold_replacement,
   input  logic                 threshold_upper,
   input  img_pkg::dim_t        pixel_count,
   input  img_pkg::addr_t       storage_base,
   input  img_pkg::word_t       data_read,
   input  logic                 data_read_valid,
   output img_pkg::addr_t       mem_addr,
   output logic                 mem_rd_en,
   output logic                 mem_wr_en,
   output img_pkg::word_t       mem_wdata,
   output logic                 busy
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_WAIT
   } state_e;

   state_e         state;
   img_pkg::addr_t word_addr;
   img_pkg::dim_t  words_left;

   function automatic img_pkg::pixel_t apply_op(img_pkg::pixel_t pix);
      img_pkg::word_t  sum;
      img_pkg::pixel_t res;
      sum = {{(`IMG_WORD_W-`IMG_PIX_W){1'b0}}, pix} + add_value;
      res = pix;
      case (op_sel)
         img_pkg::OP_ADD: begin
            res = sum[`IMG_PIX_W-1:0];
            if (clamp && $signed(sum) > 16'sd255) res = 8'hff;
            if (clamp && $signed(sum) < 16'sd0) res = 8'h00;
         end
         img_pkg::OP_THRESHOLD: begin
            if (threshold_upper ? (pix >= threshold_level) : (pix <= threshold_level))
               res = threshold_replacement;
         end
         img_pkg::OP_INVERT: res = ~pix;
         default: res = pix;
      endcase
      return res;
   endfunction

   always_ff @(posedge clk) begin
      mem_rd_en <= 1'b0;
      mem_wr_en <= 1'b0;
      if (reset) begin
         state      <= ST_IDLE;
         busy       <= 1'b0;
         word_addr  <= '0;
         words_left <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (op_start && pixel_count != '0) begin
                  word_addr  <= storage_base;
                  words_left <= (pixel_count >> 1) + {15'd0, pixel_count[0]};
                  busy       <= 1'b1;
                  state      <= ST_READ;
               end
            end
            ST_READ: begin
               mem_rd_en <= 1'b1;
               mem_addr  <= word_addr;
               state     <= ST_WAIT;
            end
            default: begin
               if (data_read_valid) begin // write back to the same word
                  mem_wr_en  <= 1'b1;
                  mem_addr   <= word_addr;
                  mem_wdata  <= {apply_op(data_read[15:8]), apply_op(data_read[7:0])};
                  word_addr  <= word_addr + 32'd2;
                  words_left <= words_left - 16'd1;
                  if (words_left == 16'd1) begin
                     busy  <= 1'b0;
                     state <= ST_IDLE;
                  end else begin
                     state <= ST_READ;
                  end
               end
            end
         endcase
      end
   end

   a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
      op_start |-> !busy)
      else $error("op_start while engine busy");

endmodule

//--- source/host_responder.sv
`timescale 1ns/100ps
`include "img_defs.svh"

module host_responder (
   input  logic            clk,
   input  logic            reset,
   input  logic            read_start,
   input  logic            status_start,
   input  img_pkg::addr_t  input_base,
   input  img_pkg::dim_t   pixel_count,
   input  logic            busy,
   input  img_pkg::word_t  data_read,
   input  logic            data_read_valid,
   output img_pkg::addr_t  mem_addr,
   output logic            mem_rd_en,
   output img_pkg::pixel_t comm_data_out,
   output logic            comm_data_out_valid
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RD_WAIT,
      ST_RD_HIGH,
      ST_STATUS
   } state_e;

   localparam img_pkg::pixel_t STATUS_0 = `IMG_STATUS_0;

   state_e          state;
   img_pkg::addr_t  rd_addr;
   img_pkg::dim_t   bytes_left;
   img_pkg::pixel_t high_byte;
   logic [1:0]      stat_idx;

   always_ff @(posedge clk) begin
      mem_rd_en           <= 1'b0;
      comm_data_out_valid <= 1'b0;
      if (reset) begin
         state      <= ST_IDLE;
         bytes_left <= '0;
         stat_idx   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               stat_idx <= '0;
               if (status_start) begin
                  state <= ST_STATUS;
               end else if (read_start && pixel_count != '0) begin
                  mem_rd_en  <= 1'b1;
                  mem_addr   <= input_base;
                  rd_addr    <= input_base;
                  bytes_left <= pixel_count;
                  state      <= ST_RD_WAIT;
               end
            end
            ST_RD_WAIT: begin
               if (data_read_valid) begin
                  comm_data_out       <= data_read[7:0]; // low byte first
                  comm_data_out_valid <= 1'b1;
                  high_byte           <= data_read[15:8];
                  bytes_left          <= bytes_left - 16'd1;
                  state <= (bytes_left == 16'd1) ? ST_IDLE : ST_RD_HIGH;
               end
            end
            ST_RD_HIGH: begin
               comm_data_out       <= high_byte;
               comm_data_out_valid <= 1'b1;
               bytes_left          <= bytes_left - 16'd1;
               if (bytes_left == 16'd1) begin
                  state <= ST_IDLE;
               end else begin
                  mem_rd_en <= 1'b1; // next word overlaps the high byte
                  mem_addr  <= rd_addr + 32'd2;
                  rd_addr   <= rd_addr + 32'd2;
                  state     <= ST_RD_WAIT;
               end
            end
            default: begin
               comm_data_out_valid <= 1'b1;
               stat_idx            <= stat_idx + 2'd1;
               case (stat_idx)
                  2'd0: comm_data_out <= {STATUS_0[7:1], busy};
                  2'd1: comm_data_out <= `IMG_STATUS_1;
                  2'd2: comm_data_out <= `IMG_STATUS_2;
                  default: begin
                     comm_data_out <= `IMG_STATUS_3;
                     state         <= ST_IDLE;
                  end
               endcase
            end
         endcase
      end
   end

   a_no_overlap: assert property (@(posedge clk) disable iff (reset)
      (read_start || status_start) |-> state == ST_IDLE)
      else $error("status and readback overlap");

endmodule

//--- source/image_processing.sv
`timescale 1ns/100ps
`include "img_defs.svh"

module image_processing (
   input  logic            clk,
   input  logic            reset,
   input  img_pkg::cmd_e   comm_cmd,
   input  img_pkg::pixel_t comm_data_in,
   input  logic            comm_data_in_valid,
   input  img_pkg::word_t  data_read,
   input  logic            data_read_valid,
   output img_pkg::addr_t  addr,
   output logic            wr_en,
   output logic            rd_en,
   output img_pkg::word_t  data_write,
   output img_pkg::pixel_t comm_data_out,
   output logic            comm_data_out_valid
);

   img_pkg::addr_t     dec_mem_addr;
   logic               dec_mem_wr_en;
   img_pkg::word_t     dec_mem_wdata;
   img_pkg::addr_t     eng_mem_addr;
   logic               eng_mem_rd_en;
   logic               eng_mem_wr_en;
   img_pkg::word_t     eng_mem_wdata;
   img_pkg::addr_t     rsp_mem_addr;
   logic               rsp_mem_rd_en;
   logic               op_start;
   img_pkg::unary_op_e op_sel;
   img_pkg::word_t     add_value;
   logic               clamp;
   img_pkg::pixel_t    threshold_level;
   img_pkg::pixel_t    threshold_replacement;
   logic               threshold_upper;
   img_pkg::dim_t      pixel_count;
   img_pkg::addr_t     storage_base;
   img_pkg::addr_t     input_base;
   logic               read_start;
   logic               status_start;
   logic               busy;

   command_decoder i_command_decoder (
      .clk, .reset, .comm_cmd, .comm_data_in, .comm_data_in_valid,
      .mem_addr(dec_mem_addr), .mem_wr_en(dec_mem_wr_en), .mem_wdata(dec_mem_wdata),
      .op_start, .op_sel, .add_value, .clamp, .threshold_level, .threshold_replacement,
      .threshold_upper, .pixel_count, .storage_base, .input_base, .read_start, .status_start
   );

   pixel_engine i_pixel_engine (
      .clk, .reset, .op_start, .op_sel, .add_value, .clamp, .threshold_level,
      .threshold_replacement, .threshold_upper, .pixel_count, .storage_base,
      .data_read, .data_read_valid,
      .mem_addr(eng_mem_addr), .mem_rd_en(eng_mem_rd_en), .mem_wr_en(eng_mem_wr_en),
      .mem_wdata(eng_mem_wdata), .busy
   );

   host_responder i_host_responder (
      .clk, .reset, .read_start, .status_start, .input_base, .pixel_count, .busy,
      .data_read, .data_read_valid,
      .mem_addr(rsp_mem_addr), .mem_rd_en(rsp_mem_rd_en), .comm_data_out, .comm_data_out_valid
   );

   // requesters never overlap, so the enables select the owner
   always_comb begin
      addr       = dec_mem_addr;
      data_write = dec_mem_wdata;
      if (eng_mem_rd_en || eng_mem_wr_en) begin
         addr       = eng_mem_addr;
         data_write = eng_mem_wdata;
      end else if (rsp_mem_rd_en) begin
         addr = rsp_mem_addr;
      end
      wr_en = dec_mem_wr_en | eng_mem_wr_en;
      rd_en = eng_mem_rd_en | rsp_mem_rd_en;
   end

   a_mem_excl: assert property (@(posedge clk) disable iff (reset)
      $onehot0({dec_mem_wr_en, eng_mem_rd_en, eng_mem_wr_en, rsp_mem_rd_en}))
      else $error("more than one memory requester active");

endmodule

//--- tests/pixel_memory.sv
`timescale 1ns/100ps
`include "img_defs.svh"

module pixel_memory (
   input  logic           clk,
   input  img_pkg::addr_t addr,
   input  logic           rd_en,
   input  logic           wr_en,
   input  img_pkg::word_t data_write,
   output img_pkg::word_t data_read,
   output logic           data_read_valid
);

   localparam int AW    = $clog2(`IMG_MEM_SIZE);
   localparam int WORDS = `IMG_MEM_SIZE / 2;

   img_pkg::word_t mem [WORDS];

   initial begin
      data_read_valid = 1'b0;
      data_read       = '0;
      // odd multiplier, so every word index gives its own value
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = img_pkg::word_t'(i) * 16'd40503;
      end
   end

   always @(posedge clk) begin
      data_read_valid <= rd_en; // answer one cycle later
      if (rd_en) data_read <= mem[addr[AW-1:1]];
      if (wr_en) mem[addr[AW-1:1]] <= data_write;
   end

endmodule

//--- tests/tb_image_processing.sv
`timescale 1ns/100ps
`include "img_defs.svh"

module tb_image_processing;

   localparam int CLK_PERIOD = 10;
   localparam img_pkg::dim_t IMG_W = 16'd8;
   localparam img_pkg::dim_t IMG_H = 16'd4;
   localparam int NPIX = int'(IMG_W) * int'(IMG_H);
   // nine send/process/read sequences, each well inside 250 cycles
   localparam int NUM_RUNS    = 9;
   localparam int RUN_CYCLES  = 250;
   localparam int WATCHDOG_NS = NUM_RUNS * RUN_CYCLES * CLK_PERIOD;

   logic            clk;
   logic            reset;
   img_pkg::cmd_e   comm_cmd;
   img_pkg::pixel_t comm_data_in;
   logic            comm_data_in_valid;
   img_pkg::word_t  data_read;
   logic            data_read_valid;
   img_pkg::addr_t  addr;
   logic            wr_en;
   logic            rd_en;
   img_pkg::word_t  data_write;
   img_pkg::pixel_t comm_data_out;
   logic            comm_data_out_valid;

   integer          seed;
   int              errors;
   img_pkg::pixel_t img [NPIX];
   img_pkg::pixel_t exp_img [NPIX];
   img_pkg::pixel_t other_img [NPIX];
   img_pkg::pixel_t rx_q [$];

   image_processing i_dut (.*);

   pixel_memory i_mem (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // every byte sent to the host
   always @(posedge clk) begin
      if (!reset && comm_data_out_valid) rx_q.push_back(comm_data_out);
   end

   a_rd_wr: assert property (@(posedge clk) disable iff (reset) !(rd_en && wr_en))
      else begin
         errors++;
         $display("memory read and write requested in the same cycle at %0t ns", $time);
      end

   a_busy_rise: assert property (@(posedge clk) disable iff (reset)
      i_dut.op_start |=> i_dut.busy)
      else begin
         errors++;
         $display("busy did not rise after op_start at %0t ns", $time);
      end

   task automatic check_byte(input string name, input img_pkg::pixel_t expected,
                             input img_pkg::pixel_t actual);
      assert (actual === expected)
      else begin
         errors++;
         $display("FAILED %0t ns %s expected 0x%02h got 0x%02h",
                  $time, name, expected, actual);
      end
   endtask

   task automatic put_byte(input img_pkg::cmd_e cmd, input img_pkg::pixel_t data);
      @(posedge clk);
      #1;
      comm_cmd           = cmd;
      comm_data_in       = data;
      comm_data_in_valid = 1'b1;
   endtask

   task automatic release_port();
      @(posedge clk);
      #1;
      comm_data_in_valid = 1'b0;
   endtask

   task automatic wait_bytes(input int n);
      while (rx_q.size() < n) @(posedge clk);
   endtask

   task automatic set_dims(input img_pkg::dim_t w, input img_pkg::dim_t h);
      put_byte(img_pkg::CMD_PARAM, 8'h00);
      put_byte(img_pkg::CMD_PARAM, w[7:0]); // low byte first
      put_byte(img_pkg::CMD_PARAM, w[15:8]);
      put_byte(img_pkg::CMD_PARAM, h[7:0]);
      put_byte(img_pkg::CMD_PARAM, h[15:8]);
      release_port();
   endtask

   task automatic random_image();
      foreach (img[i]) img[i] = img_pkg::pixel_t'($random(seed));
   endtask

   task automatic send_image();
      put_byte(img_pkg::CMD_SEND_IMG, 8'h00);
      foreach (img[i]) put_byte(img_pkg::CMD_PARAM, img[i]);
      release_port();
   endtask

   task automatic switch_buffers();
      put_byte(img_pkg::CMD_SWITCH_BUFFERS, 8'h00);
      release_port();
   endtask

   task automatic get_status(output logic busy_bit);
      img_pkg::pixel_t first;
      put_byte(img_pkg::CMD_GET_STATUS, 8'h00);
      release_port();
      wait_bytes(4);
      first    = rx_q.pop_front();
      busy_bit = first[0];
      // bit 0 carries busy, so only the upper bits are fixed
      check_byte("comm_data_out (status 0)", `IMG_STATUS_0 | 8'h01, {first[7:1], 1'b1});
      check_byte("comm_data_out (status 1)", `IMG_STATUS_1, rx_q.pop_front());
      check_byte("comm_data_out (status 2)", `IMG_STATUS_2, rx_q.pop_front());
      check_byte("comm_data_out (status 3)", `IMG_STATUS_3, rx_q.pop_front());
   endtask

   task automatic wait_engine();
      logic b;
      get_status(b);
      check_byte("status busy bit", 8'd1, {7'd0, b}); // right after op_start
      while (b) get_status(b);
   endtask

   task automatic read_and_check(input string what);
      img_pkg::pixel_t got;
      put_byte(img_pkg::CMD_READ_IMG, 8'h00);
      release_port();
      wait_bytes(NPIX);
      for (int i = 0; i < NPIX; i++) begin
         got = rx_q.pop_front();
         check_byte($sformatf("comm_data_out (%s byte %0d)", what, i), exp_img[i], got);
      end
   endtask

   // expected pixel for each operation
   function automatic img_pkg::pixel_t model_pixel(input img_pkg::unary_op_e op,
         input img_pkg::pixel_t pix, input img_pkg::word_t value,
         input img_pkg::pixel_t repl, input logic flag);
      int sum;
      img_pkg::pixel_t res;
      res = pix;
      case (op)
         img_pkg::OP_ADD: begin
            sum = int'(pix) + int'(value);
            if (sum >= 65536) sum -= 65536; // 16-bit sum
            if (sum >= 32768) sum -= 65536; // read as signed
            if (!flag) res = img_pkg::pixel_t'(sum);
            else if (sum < 0) res = 8'd0;
            else if (sum > 255) res = 8'd255;
            else res = img_pkg::pixel_t'(sum);
         end
         img_pkg::OP_THRESHOLD: begin
            if (flag ? (pix >= value[7:0]) : (pix <= value[7:0])) res = repl;
         end
         default: res = ~pix;
      endcase
      return res;
   endfunction

   task automatic issue_op(input img_pkg::unary_op_e op, input img_pkg::word_t value,
                           input img_pkg::pixel_t repl, input logic flag);
      case (op)
         img_pkg::OP_ADD: begin
            put_byte(img_pkg::CMD_APPLY_ADD, 8'h00);
            put_byte(img_pkg::CMD_PARAM, value[7:0]);
            put_byte(img_pkg::CMD_PARAM, value[15:8]);
            put_byte(img_pkg::CMD_PARAM, {7'd0, flag});
         end
         img_pkg::OP_THRESHOLD: begin
            put_byte(img_pkg::CMD_APPLY_THRESHOLD, 8'h00);
            put_byte(img_pkg::CMD_PARAM, value[7:0]);
            put_byte(img_pkg::CMD_PARAM, repl);
            put_byte(img_pkg::CMD_PARAM, {7'd0, flag});
         end
         default: put_byte(img_pkg::CMD_APPLY_INVERT, 8'h00);
      endcase
      release_port();
   endtask

   // send, process in the storage buffer, swap back and read
   task automatic run_op(input img_pkg::unary_op_e op, input img_pkg::word_t value,
                         input img_pkg::pixel_t repl, input logic flag, input string what);
      random_image();
      send_image();
      switch_buffers();
      issue_op(op, value, repl, flag);
      wait_engine();
      switch_buffers();
      foreach (img[i]) exp_img[i] = model_pixel(op, img[i], value, repl, flag);
      read_and_check(what);
   endtask

   initial begin
      logic b;
      seed               = 61881;
      errors             = 0;
      reset              = 1'b1;
      comm_cmd           = img_pkg::CMD_PARAM;
      comm_data_in       = '0;
      comm_data_in_valid = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;

      set_dims(IMG_W, IMG_H);
      random_image();
      send_image();
      exp_img = img;
      read_and_check("readback");

      get_status(b);
      check_byte("status busy bit", 8'd0, {7'd0, b}); // idle engine

      run_op(img_pkg::OP_ADD, 16'd100, 8'h00, 1'b1, "add clamp");
      run_op(img_pkg::OP_ADD, 16'hffc4, 8'h00, 1'b1, "add clamp negative");
      run_op(img_pkg::OP_ADD, 16'd200, 8'h00, 1'b0, "add wrap");
      run_op(img_pkg::OP_THRESHOLD, 16'd128, 8'h55, 1'b1, "threshold upper");
      run_op(img_pkg::OP_THRESHOLD, 16'd90, 8'haa, 1'b0, "threshold lower");

      // park a second image in the other buffer
      switch_buffers();
      random_image();
      other_img = img;
      send_image();
      switch_buffers();
      run_op(img_pkg::OP_INVERT, 16'd0, 8'h00, 1'b0, "invert");
      switch_buffers(); // untouched buffer comes back
      exp_img = other_img;
      read_and_check("unprocessed buffer");
      switch_buffers();

      repeat (4) @(posedge clk);
      if (rx_q.size() != 0) begin
         errors++;
         $display("the DUT sent %0d bytes that were not requested", rx_q.size());
      end
      $display("checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      errors++;
      $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("checks done, errors: %0d", errors);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- compile.f
+incdir+source
source/img_pkg.sv
source/command_decoder.sv
source/pixel_engine.sv
source/host_responder.sv
source/image_processing.sv
tests/pixel_memory.sv
tests/tb_image_processing.sv

//--- run_sim.sh
#!/bin/sh
# build and run the image coprocessor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_image_processing -f compile.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Simulation passed" sim.log; then
   exit 0
fi
exit 1
